//--- hdl/irda_cfg.svh
`ifndef IRDA_CFG_SVH
`define IRDA_CFG_SVH

// entries per FIFO, keep it a power of two
`define IRDA_FIFO_DEPTH 8

// clock divisor register width
`define IRDA_CDR_WIDTH 16

// APB word address width
`define IRDA_ADDR_WIDTH 4

// both FIFO reset bits set, so the FIFOs are flushed right after reset
`define IRDA_FCR_RESET 8'h03

`endif

//--- hdl/irda_reg_pkg.sv
`default_nettype none

`include "irda_cfg.svh"

package irda_reg_pkg;

	// word addresses of the register map
	typedef enum logic [`IRDA_ADDR_WIDTH-1:0] {
		ADDR_TRANSMITTER = 0, // write only
		ADDR_RECEIVER    = 1, // read only
		ADDR_IER         = 2,
		ADDR_IIR         = 3,
		ADDR_FCR         = 4,
		ADDR_LCR         = 5,
		ADDR_OFDLR       = 6,
		ADDR_IFDLR       = 7,
		ADDR_CDR         = 8
	} reg_addr_e;

	// interrupt enables, same bit order as IIR
	typedef struct packed {
		logic frame_sent;
		logic tx_empty;
		logic rx_avail;
	} ier_t;

	typedef struct packed {
		logic [5:0] spare;  // stored, no function
		logic       rx_rst; // self clearing
		logic       tx_rst; // self clearing
	} fcr_t;

	typedef struct packed {
		logic rx_en;
		logic tx_en;
	} lcr_t;

endpackage

`default_nettype wire

//--- hdl/irda_line_pkg.sv
`default_nettype none

package irda_line_pkg;

	// one entry of the rx FIFO, flag lands in bit 8 on a RECEIVER read
	typedef struct packed {
		logic       frame_end;
		logic [7:0] data;
	} rx_word_t;

	// shared by transmitter and receiver
	typedef enum logic [1:0] {
		LS_IDLE,
		LS_START,
		LS_DATA,
		LS_STOP
	} line_state_e;

endpackage

`default_nettype wire

//--- hdl/irda_reg_if.sv
`timescale 1ns/100ps
`default_nettype none

`include "irda_cfg.svh"

interface irda_reg_if;

	// register outputs
	irda_reg_pkg::ier_t          ier;
	irda_reg_pkg::fcr_t          fcr;
	irda_reg_pkg::lcr_t          lcr;
	logic [15:0]                 ofdlr;
	logic [`IRDA_CDR_WIDTH-1:0]  cdr;
	logic                        en_reload; // one cycle after a CDR write

	// FIFO strobes from the register block
	logic                        tx_push;
	logic [7:0]                  tx_wdata;
	logic                        rx_pop;

	// status back into the register block
	logic                        tx_full;
	logic                        tx_empty;
	irda_line_pkg::rx_word_t     rx_rdata;
	logic                        rx_empty;
	logic                        rx_byte;    // a byte was stored in the rx FIFO
	logic                        frame_sent; // pulse after the last stop bit

	modport regs (
		output ier, fcr, lcr, ofdlr, cdr, en_reload, tx_push, tx_wdata, rx_pop,
		input  tx_full, tx_empty, rx_rdata, rx_empty, rx_byte, frame_sent
	);

	modport line (
		input  lcr, ofdlr, cdr, en_reload,
		output rx_byte, frame_sent
	);

	modport fifo_side (
		input  fcr, tx_push, tx_wdata, rx_pop,
		output tx_full, tx_empty, rx_rdata, rx_empty
	);

endinterface

`default_nettype wire

//--- hdl/irda_f_regs.sv
`timescale 1ns/100ps
`default_nettype none

`include "irda_cfg.svh"

module irda_f_regs (
	input  wire logic                        clk,
	input  wire logic                        wb_rst_i,
	input  wire logic [`IRDA_ADDR_WIDTH-1:0] paddr_i,
	input  wire logic                        psel_i,
	input  wire logic                        penable_i,
	input  wire logic                        pwrite_i,
	input  wire logic [31:0]                 pwdata_i,
	output logic      [31:0]                 prdata_o,
	output logic                             pslverr_o,
	output logic                             irq_o,
	irda_reg_if.regs                         regs_if
);

	logic        setup;
	logic        access;
	logic        wr;
	logic        rd;
	logic        iir_rd;
	logic        frame_flag; // sticky until IIR is read
	logic [15:0] ifdlr;
	logic [2:0]  status;     // same layout as IER
	logic [31:0] rd_mux;

	assign setup  = psel_i & ~penable_i;
	assign access = psel_i & penable_i;
	assign wr     = access & pwrite_i;
	assign rd     = access & ~pwrite_i;
	assign iir_rd = rd && paddr_i == irda_reg_pkg::ADDR_IIR;

	// push and pop land on the edge that ends the access cycle
	assign regs_if.tx_push  = wr && paddr_i == irda_reg_pkg::ADDR_TRANSMITTER;
	assign regs_if.tx_wdata = pwdata_i[7:0];
	assign regs_if.rx_pop   = rd && paddr_i == irda_reg_pkg::ADDR_RECEIVER;

	assign status = {frame_flag, regs_if.tx_empty, ~regs_if.rx_empty};
	assign irq_o  = |(regs_if.ier & status);

	always_comb begin
		pslverr_o = 1'b0;
		if (access) begin
			if (paddr_i > irda_reg_pkg::ADDR_CDR)
				pslverr_o = 1'b1; // hole in the map
			else if (pwrite_i && paddr_i == irda_reg_pkg::ADDR_TRANSMITTER)
				pslverr_o = regs_if.tx_full;
			else if (!pwrite_i && paddr_i == irda_reg_pkg::ADDR_RECEIVER)
				pslverr_o = regs_if.rx_empty;
		end
	end

	always_comb begin
		rd_mux = '0;
		case (paddr_i)
			irda_reg_pkg::ADDR_RECEIVER: rd_mux[8:0]  = regs_if.rx_rdata;
			irda_reg_pkg::ADDR_IER:      rd_mux[2:0]  = regs_if.ier;
			irda_reg_pkg::ADDR_IIR:      rd_mux[2:0]  = status;
			irda_reg_pkg::ADDR_FCR:      rd_mux[7:0]  = regs_if.fcr;
			irda_reg_pkg::ADDR_LCR:      rd_mux[1:0]  = regs_if.lcr;
			irda_reg_pkg::ADDR_OFDLR:    rd_mux[15:0] = regs_if.ofdlr;
			irda_reg_pkg::ADDR_IFDLR:    rd_mux[15:0] = ifdlr;
			irda_reg_pkg::ADDR_CDR:      rd_mux[`IRDA_CDR_WIDTH-1:0] = regs_if.cdr;
			default:                     rd_mux = '0;
		endcase
	end

	// read data is taken in the setup cycle, valid through the access cycle
	always_ff @(posedge clk or posedge wb_rst_i) begin
		if (wb_rst_i)
			prdata_o <= '0;
		else if (setup && !pwrite_i)
			prdata_o <= rd_mux;
	end

	always_ff @(posedge clk or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			regs_if.ier       <= '0;
			regs_if.fcr       <= `IRDA_FCR_RESET;
			regs_if.lcr       <= '0;
			regs_if.ofdlr     <= '0;
			regs_if.cdr       <= '0;
			regs_if.en_reload <= 1'b0;
		end else begin
			regs_if.en_reload  <= wr && paddr_i == irda_reg_pkg::ADDR_CDR;
			regs_if.fcr.tx_rst <= 1'b0; // reset bits only live one cycle
			regs_if.fcr.rx_rst <= 1'b0;
			if (wr) begin
				case (paddr_i)
					irda_reg_pkg::ADDR_IER:   regs_if.ier   <= pwdata_i[2:0];
					irda_reg_pkg::ADDR_FCR:   regs_if.fcr   <= pwdata_i[7:0];
					irda_reg_pkg::ADDR_LCR:   regs_if.lcr   <= pwdata_i[1:0];
					irda_reg_pkg::ADDR_OFDLR: regs_if.ofdlr <= pwdata_i[15:0];
					irda_reg_pkg::ADDR_CDR:
						regs_if.cdr <= pwdata_i[`IRDA_CDR_WIDTH-1:0];
					default: ;
				endcase
			end
		end
	end

	// frame-sent flag and incoming byte count, both cleared by an IIR read
	always_ff @(posedge clk or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			frame_flag <= 1'b0;
			ifdlr      <= '0;
		end else begin
			if (regs_if.frame_sent)
				frame_flag <= 1'b1; // a new frame wins over the clear
			else if (iir_rd)
				frame_flag <= 1'b0;
			if (iir_rd)
				ifdlr <= {15'b0, regs_if.rx_byte};
			else if (regs_if.rx_byte)
				ifdlr <= ifdlr + 16'd1;
		end
	end

endmodule

`default_nettype wire

//--- hdl/irda_fifo.sv
`timescale 1ns/100ps
`default_nettype none

`include "irda_cfg.svh"

module irda_fifo #(
	parameter type payload_t = logic [7:0]
) (
	input  wire logic                              clk,
	input  wire logic                              wb_rst_i,
	input  wire logic                              clr_i,
	input  wire logic                              push_i,
	input  wire payload_t                          wdata_i,
	input  wire logic                              pop_i,
	output payload_t                               rdata_o,
	output logic                                   full_o,
	output logic                                   empty_o,
	output logic [$clog2(`IRDA_FIFO_DEPTH):0]      count_o
);

	localparam int AW = $clog2(`IRDA_FIFO_DEPTH);

	payload_t        mem [`IRDA_FIFO_DEPTH];
	logic [AW-1:0]   wr_ptr;
	logic [AW-1:0]   rd_ptr;
	logic            do_push;
	logic            do_pop;

	assign full_o  = count_o == `IRDA_FIFO_DEPTH;
	assign empty_o = count_o == '0;
	assign do_push = push_i & ~full_o;  // push on full is dropped
	assign do_pop  = pop_i & ~empty_o;
	assign rdata_o = mem[rd_ptr];       // head is always visible

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= wdata_i;
	end

	always_ff @(posedge clk or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count_o <= '0;
		end else if (clr_i) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count_o <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1; // wraps at depth
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			count_o <= count_o + do_push - do_pop;
		end
	end

endmodule

`default_nettype wire

//--- hdl/irda_fast_enable.sv
`timescale 1ns/100ps
`default_nettype none

`include "irda_cfg.svh"

module irda_fast_enable (
	input  wire logic clk,
	input  wire logic wb_rst_i,
	irda_reg_if.line  line_if,
	output logic      bit_en_o
);

	logic [`IRDA_CDR_WIDTH-1:0] cnt;

	// one tick every cdr+1 clocks
	always_ff @(posedge clk or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			cnt      <= '0;
			bit_en_o <= 1'b0;
		end else if (line_if.en_reload) begin
			cnt      <= line_if.cdr; // new divisor, start over
			bit_en_o <= 1'b0;
		end else if (cnt == '0) begin
			cnt      <= line_if.cdr;
			bit_en_o <= 1'b1;
		end else begin
			cnt      <= cnt - 1'b1;
			bit_en_o <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- hdl/irda_f_tx.sv
`timescale 1ns/100ps
`default_nettype none

`include "irda_cfg.svh"

module irda_f_tx (
	input  wire logic                          clk,
	input  wire logic                          wb_rst_i,
	input  wire logic                          bit_en_i,
	irda_reg_if.line                           line_if,
	input  wire logic [7:0]                    txf_rdata_i,
	input  wire logic                          txf_empty_i,
	input  wire logic [$clog2(`IRDA_FIFO_DEPTH):0] txf_count_i,
	output logic                               txf_pop_o,
	output logic                               irda_tx_o
);

	irda_line_pkg::line_state_e state;
	logic [7:0]  shreg;
	logic [2:0]  bit_cnt;
	logic [15:0] byte_cnt;
	logic        can_start;

	// a whole frame has to be waiting, so we never stall mid frame
	assign can_start = line_if.lcr.tx_en && line_if.ofdlr != '0 &&
		16'(txf_count_i) >= line_if.ofdlr;

	always_ff @(posedge clk or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			state              <= irda_line_pkg::LS_IDLE;
			shreg              <= '0;
			bit_cnt            <= '0;
			byte_cnt           <= '0;
			txf_pop_o          <= 1'b0;
			irda_tx_o          <= 1'b1; // line idles high
			line_if.frame_sent <= 1'b0;
		end else begin
			txf_pop_o          <= 1'b0;
			line_if.frame_sent <= 1'b0;
			if (bit_en_i) begin
				case (state)
					irda_line_pkg::LS_IDLE: begin
						if (can_start) begin
							shreg     <= txf_rdata_i;
							txf_pop_o <= 1'b1;
							byte_cnt  <= 16'd1;
							irda_tx_o <= 1'b0; // start bit
							state     <= irda_line_pkg::LS_START;
						end
					end
					irda_line_pkg::LS_START: begin
						irda_tx_o <= shreg[0]; // lsb first
						shreg     <= shreg >> 1;
						bit_cnt   <= '0;
						state     <= irda_line_pkg::LS_DATA;
					end
					irda_line_pkg::LS_DATA: begin
						if (bit_cnt == 3'd7) begin
							irda_tx_o <= 1'b1; // stop bit
							state     <= irda_line_pkg::LS_STOP;
						end else begin
							irda_tx_o <= shreg[0];
							shreg     <= shreg >> 1;
							bit_cnt   <= bit_cnt + 1'b1;
						end
					end
					irda_line_pkg::LS_STOP: begin
						if (byte_cnt == line_if.ofdlr) begin
							line_if.frame_sent <= 1'b1;
							state              <= irda_line_pkg::LS_IDLE;
						end else if (txf_empty_i) begin
							state <= irda_line_pkg::LS_IDLE; // FIFO flushed under us
						end else begin
							shreg     <= txf_rdata_i;
							txf_pop_o <= 1'b1;
							byte_cnt  <= byte_cnt + 16'd1;
							irda_tx_o <= 1'b0;
							state     <= irda_line_pkg::LS_START;
						end
					end
					default: state <= irda_line_pkg::LS_IDLE;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/irda_f_rx.sv
`timescale 1ns/100ps
`default_nettype none

module irda_f_rx (
	input  wire logic               clk,
	input  wire logic               wb_rst_i,
	input  wire logic               bit_en_i,
	input  wire logic               irda_rx_i,
	irda_reg_if.line                line_if,
	input  wire logic               rxf_full_i,
	output logic                    rxf_push_o,
	output irda_line_pkg::rx_word_t rxf_wdata_o
);

	irda_line_pkg::line_state_e state;
	logic [1:0]  rx_sync;
	logic        rx_s;
	logic [7:0]  shreg;
	logic [2:0]  bit_cnt;
	logic [15:0] rx_cnt; // bytes of the current frame so far
	logic        last;

	assign rx_s = rx_sync[1];
	assign last = rx_cnt + 16'd1 == line_if.ofdlr;

	always_ff @(posedge clk or posedge wb_rst_i) begin
		if (wb_rst_i)
			rx_sync <= 2'b11;
		else
			rx_sync <= {rx_sync[0], irda_rx_i};
	end

	always_ff @(posedge clk) begin
		if (bit_en_i && state == irda_line_pkg::LS_STOP) begin
			rxf_wdata_o.data      <= shreg;
			rxf_wdata_o.frame_end <= last;
		end
	end

	always_ff @(posedge clk or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			state           <= irda_line_pkg::LS_IDLE;
			shreg           <= '0;
			bit_cnt         <= '0;
			rx_cnt          <= '0;
			rxf_push_o      <= 1'b0;
			line_if.rx_byte <= 1'b0;
		end else begin
			rxf_push_o      <= 1'b0;
			line_if.rx_byte <= 1'b0;
			if (bit_en_i) begin
				case (state)
					irda_line_pkg::LS_IDLE:
						if (line_if.lcr.rx_en && !rx_s)
							state <= irda_line_pkg::LS_START;
					irda_line_pkg::LS_START: begin
						shreg   <= {rx_s, shreg[7:1]}; // bit 0
						bit_cnt <= 3'd1;
						state   <= irda_line_pkg::LS_DATA;
					end
					irda_line_pkg::LS_DATA: begin
						shreg   <= {rx_s, shreg[7:1]};
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7)
							state <= irda_line_pkg::LS_STOP;
					end
					irda_line_pkg::LS_STOP: begin
						// bad stop bit or full FIFO drops the byte
						if (rx_s && !rxf_full_i) begin
							rxf_push_o      <= 1'b1;
							line_if.rx_byte <= 1'b1;
							rx_cnt          <= last ? '0 : rx_cnt + 16'd1;
						end
						state <= irda_line_pkg::LS_IDLE;
					end
					default: state <= irda_line_pkg::LS_IDLE;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/irda_fast_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "irda_cfg.svh"

module irda_fast_top (
	input  wire logic                        clk,
	input  wire logic                        wb_rst_i,
	input  wire logic [`IRDA_ADDR_WIDTH-1:0] paddr_i,
	input  wire logic                        psel_i,
	input  wire logic                        penable_i,
	input  wire logic                        pwrite_i,
	input  wire logic [31:0]                 pwdata_i,
	input  wire logic                        irda_rx_i,
	output logic      [31:0]                 prdata_o,
	output logic                             pready_o,
	output logic                             pslverr_o,
	output logic                             irq_o,
	output logic                             irda_tx_o
);

	irda_reg_if reg_if ();

	logic                              bit_en;
	logic                              txf_pop;
	logic [7:0]                        txf_rdata;
	logic [$clog2(`IRDA_FIFO_DEPTH):0] txf_count;
	logic                              rxf_push;
	logic                              rxf_full;
	irda_line_pkg::rx_word_t           rxf_wdata;

	assign pready_o = 1'b1; // zero wait states

	irda_f_regs u_regs (
		.clk, .wb_rst_i, .paddr_i, .psel_i, .penable_i, .pwrite_i, .pwdata_i,
		.prdata_o, .pslverr_o, .irq_o,
		.regs_if (reg_if.regs)
	);

	irda_fifo #(.payload_t(logic [7:0])) u_tx_fifo (
		.clk, .wb_rst_i,
		.clr_i   (reg_if.fcr.tx_rst),
		.push_i  (reg_if.tx_push),
		.wdata_i (reg_if.tx_wdata),
		.pop_i   (txf_pop),
		.rdata_o (txf_rdata),
		.full_o  (reg_if.tx_full),
		.empty_o (reg_if.tx_empty),
		.count_o (txf_count)
	);

	irda_fifo #(.payload_t(irda_line_pkg::rx_word_t)) u_rx_fifo (
		.clk, .wb_rst_i,
		.clr_i   (reg_if.fcr.rx_rst),
		.push_i  (rxf_push),
		.wdata_i (rxf_wdata),
		.pop_i   (reg_if.rx_pop),
		.rdata_o (reg_if.rx_rdata),
		.full_o  (rxf_full),
		.empty_o (reg_if.rx_empty),
		.count_o ()
	);

	irda_fast_enable u_enable (
		.clk, .wb_rst_i, .line_if (reg_if.line), .bit_en_o (bit_en)
	);

	irda_f_tx u_tx (
		.clk, .wb_rst_i, .bit_en_i (bit_en), .line_if (reg_if.line),
		.txf_rdata_i (txf_rdata), .txf_empty_i (reg_if.tx_empty),
		.txf_count_i (txf_count), .txf_pop_o (txf_pop), .irda_tx_o
	);

	irda_f_rx u_rx (
		.clk, .wb_rst_i, .bit_en_i (bit_en), .irda_rx_i, .line_if (reg_if.line),
		.rxf_full_i (rxf_full), .rxf_push_o (rxf_push), .rxf_wdata_o (rxf_wdata)
	);

endmodule

`default_nettype wire

//--- test/irda_fast_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "irda_cfg.svh"

module irda_fast_tb;

	localparam real CLK_PERIOD = 100.0;
	localparam int  LOOP_BYTES = 4;  // bytes in the loopback frame
	localparam int  LOOP_CDR   = 3;
	localparam int  BIT_CYCLES = LOOP_CDR + 1;
	localparam int  IRQ_WAIT   = 2 * LOOP_BYTES * 10 * BIT_CYCLES; // cycles
	localparam int  MARGIN     = 3000; // register traffic and idle checks
	localparam real RUN_LIMIT  = LOOP_BYTES * 10 * BIT_CYCLES * CLK_PERIOD * 4
		+ MARGIN * CLK_PERIOD;

	logic                        clk;
	logic                        wb_rst_i;
	logic [`IRDA_ADDR_WIDTH-1:0] paddr;
	logic                        psel;
	logic                        penable;
	logic                        pwrite;
	logic [31:0]                 pwdata;
	logic [31:0]                 prdata;
	logic                        pready;
	logic                        pslverr;
	logic                        irq;
	wire                         irda_line; // tx looped back into rx

	int                          checks;
	int                          errors;
	int                          fd;
	int                          code;
	logic [31:0]                 rnd;
	logic [8*256-1:0]            line_buf;
	logic [8*32-1:0]             name;
	logic [8*32-1:0]             op;
	logic [`IRDA_ADDR_WIDTH-1:0] addr;
	logic [31:0]                 data;
	logic [31:0]                 expect_v;
	logic [31:0]                 err_exp;
	logic [8:0]                  rx_model [$]; // {frame_end, byte} in send order

	irda_fast_top u_dut (
		.clk       (clk),
		.wb_rst_i  (wb_rst_i),
		.paddr_i   (paddr),
		.psel_i    (psel),
		.penable_i (penable),
		.pwrite_i  (pwrite),
		.pwdata_i  (pwdata),
		.irda_rx_i (irda_line),
		.prdata_o  (prdata),
		.pready_o  (pready),
		.pslverr_o (pslverr),
		.irq_o     (irq),
		.irda_tx_o (irda_line)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic check_value(input logic [8*32-1:0] tname, input logic [31:0] exp,
		input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("FAIL %0s: expected %h, actual %h", tname, exp, act);
		end
	endtask

	task automatic apb_write(input logic [`IRDA_ADDR_WIDTH-1:0] a, input logic [31:0] d,
		output logic err);
		@(negedge clk);
		paddr   = a;
		pwdata  = d;
		pwrite  = 1'b1;
		psel    = 1'b1;
		penable = 1'b0;
		@(negedge clk);
		penable = 1'b1;
		#(CLK_PERIOD / 10); // still in the low phase
		err = pslverr;
		check_value(name, 32'd1, {31'b0, pready}); // no wait states
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_read(input logic [`IRDA_ADDR_WIDTH-1:0] a, output logic [31:0] d,
		output logic err);
		@(negedge clk);
		paddr   = a;
		pwrite  = 1'b0;
		psel    = 1'b1;
		penable = 1'b0;
		@(negedge clk);
		penable = 1'b1;
		#(CLK_PERIOD / 10);
		d   = prdata;
		err = pslverr;
		check_value(name, 32'd1, {31'b0, pready});
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic wait_irq(input logic [8*32-1:0] tname);
		int n;
		n = 0;
		while (!irq && n < IRQ_WAIT) begin
			@(negedge clk);
			n++;
		end
		if (!irq) begin
			errors++;
			$display("%0s: irq_o did not rise within %0d cycles", tname, IRQ_WAIT);
		end
	endtask

	// one line of the stimulus file
	task automatic run_step();
		logic [31:0] rdata;
		logic        err;
		logic [8:0]  word;
		logic        line_min;
		case (op)
			"W": begin
				apb_write(addr, data, err);
				check_value(name, err_exp, err);
			end
			"R": begin
				apb_read(addr, rdata, err);
				check_value(name, expect_v, rdata);
				check_value(name, err_exp, err);
			end
			"E": begin
				apb_read(addr, rdata, err); // data is don't care here
				check_value(name, err_exp, err);
			end
			"P": begin
				for (int i = 0; i < data; i++) begin
					rnd  = $urandom;
					word = {(i == data - 1) ? expect_v[0] : 1'b0, rnd[7:0]};
					apb_write(irda_reg_pkg::ADDR_TRANSMITTER, {24'b0, word[7:0]}, err);
					check_value(name, err_exp, err);
					if (!err)
						rx_model.push_back(word);
				end
			end
			"F": begin
				repeat (data) begin
					rnd = $urandom; // filler that is never sent
					apb_write(irda_reg_pkg::ADDR_TRANSMITTER, {24'b0, rnd[7:0]}, err);
					check_value(name, err_exp, err);
				end
			end
			"Q": begin
				repeat (data) begin
					wait_irq(name);
					if (rx_model.size() == 0) begin
						errors++;
						$display("%0s: RECEIVER read with no byte left to expect", name);
					end else begin
						word = rx_model.pop_front();
						apb_read(irda_reg_pkg::ADDR_RECEIVER, rdata, err);
						check_value(name, {23'b0, word}, rdata);
						check_value(name, err_exp, err);
					end
				end
			end
			"WAITIRQ": wait_irq(name);
			"IRQ":     check_value(name, expect_v, {31'b0, irq});
			"IDLE": begin
				line_min = 1'b1;
				repeat (data) begin
					@(negedge clk);
					line_min = line_min & irda_line;
				end
				check_value(name, expect_v, {31'b0, line_min});
			end
			default: begin
				errors++;
				$display("%0s: unknown operation %0s in the stimulus file", name, op);
			end
		endcase
	endtask

	task automatic finish_run(input logic timed_out);
		$display("%0d checks, %0d errors%0s", checks, errors,
			timed_out ? ", stopped by the watchdog" : "");
		if (errors == 0 && !timed_out)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	endtask

	initial begin
		wb_rst_i = 1'b1;
		paddr    = '0;
		psel     = 1'b0;
		penable  = 1'b0;
		pwrite   = 1'b0;
		pwdata   = '0;
		checks   = 0;
		errors   = 0;
		rnd      = $urandom(68816);
		repeat (4) @(negedge clk);
		wb_rst_i = 1'b0;
		fd = $fopen("test/irda_fast_stimulus.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("could not open test/irda_fast_stimulus.txt");
		end else begin
			while (!$feof(fd)) begin
				line_buf = '0;
				code = $fgets(line_buf, fd);
				// comment and blank lines give fewer than six fields
				if (code > 0 && $sscanf(line_buf, "%s %s %h %h %h %h", name, op, addr,
					data, expect_v, err_exp) == 6)
					run_step();
			end
			$fclose(fd);
		end
		finish_run(1'b0);
	end

	initial begin
		#(RUN_LIMIT);
		$display("watchdog expired at %0t, the run did not finish", $time);
		finish_run(1'b1);
	end

endmodule

`default_nettype wire

//--- test/irda_fast_stimulus.txt
# test op addr data expect err   (addr, data, expect, err in hex; err is the expected pslverr)
# ops: W write, R read, E read for error only, P/F push N bytes, Q read N bytes, WAITIRQ, IRQ, IDLE
reset IRQ 0 0 0 0
reset R 2 0 0 0
reset R 5 0 0 0
reset R 8 0 0 0
reset R 3 0 2 0
reset R 4 0 0 0
mask W 2 ff 0 0
mask R 2 0 7 0
mask IRQ 0 0 1 0
mask W 5 ff 0 0
mask R 5 0 3 0
mask W 6 12345 0 0
mask R 6 0 2345 0
mask W 8 abcde 0 0
mask R 8 0 bcde 0
mask W 4 ff 0 0
mask R 4 0 fc 0
loopback W 8 3 0 0
loopback W 6 4 0 0
loopback W 2 1 0 0
loopback W 5 3 0 0
loopback P 0 4 1 0
loopback WAITIRQ 0 0 0 0
loopback Q 1 4 0 0
loopback R 7 0 4 0
frame R 3 0 6 0
frame R 3 0 2 0
frame R 7 0 0 0
error R 9 0 0 1
error E 1 0 0 1
error W 5 0 0 0
error F 0 8 0 0
error W 0 5a 0 1
error R 3 0 0 0
flush W 4 1 0 0
flush R 3 0 2 0
flush R 4 0 0 0
flush W 5 1 0 0
flush IDLE 0 c8 1 0

//--- tb.f
+incdir+hdl
hdl/irda_reg_pkg.sv
hdl/irda_line_pkg.sv
hdl/irda_reg_if.sv
hdl/irda_f_regs.sv
hdl/irda_fifo.sv
hdl/irda_fast_enable.sv
hdl/irda_f_tx.sv
hdl/irda_f_rx.sv
hdl/irda_fast_top.sv
test/irda_fast_tb.sv
